//--- all.f
+incdir+design
design/pid_pkg.sv
design/pid_cfg_if.sv
design/pid_regs.sv
design/oversample_filter.sv
design/pid_core.sv
design/output_preprocessor.sv
design/dac_controller.sv
design/pid_controller.sv
test/pid_controller_sva.sv
test/tb_pid_controller.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Idesign
TOP      = tb_pid_controller
FILELIST = all.f
OBJDIR   = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -Idesign --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass only when the pass message shows up in the output
sim: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf $(OBJDIR)

//--- test/tb_pid_controller.sv
`timescale 1ns/1ps

`include "pid_config.svh"

module tb_pid_controller;
	import pid_pkg::*;

	localparam int LIMIT = 400;  // cycles any single wait may take

	logic        clk50;
	logic        arst_n;
	logic        psel, penable, pwrite;
	apb_addr_t   paddr;
	apb_data_t   pwdata, prdata;
	logic        pready, pslverr;
	adc_sample_t adc_data;
	logic        adc_valid;
	logic        dac_nsync, dac_sclk, dac_din;

	int seed;
	int errors, test_errs, tests_run, tests_failed;

	// model state mirroring the apb writes
	logic                    m_lock;
	int                      m_osm;
	adc_sample_t             m_sp;
	coef_t                   m_p, m_i, m_d;
	logic [`PID_W_MLT-1:0]   m_mult;
	logic [`PID_W_SHIFT-1:0] m_shift;
	dac_code_t               m_init, m_min, m_max;
	longint                  m_integ, m_prev;

	pid_controller dut (.*);

	always #5 clk50 = ~clk50;

	////////////////////////////////////////
	// checks and bookkeeping
	////////////////////////////////////////
	task automatic report_timeout(input string what);
		errors++;
		test_errs++;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
		if (exp !== act) begin
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_code(input string name, input dac_code_t exp, input dac_code_t act);
		if (exp !== act) begin
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	// compares the header fields only
	task automatic check_frame_hdr(input string name, input dac_frame_t exp, input dac_frame_t act);
		if (exp.f.prefix !== act.f.prefix || exp.f.control !== act.f.control
			|| exp.f.address !== act.f.address || exp.f.feature !== act.f.feature) begin
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, exp.raw, act.raw);
			errors++;
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs == 0)
			$display("test %s: ok", name);
		else begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	////////////////////////////////////////
	// apb master
	////////////////////////////////////////
	task automatic apb_access(input logic wr, input apb_addr_t a, input apb_data_t d,
		output apb_data_t rd, output logic err);
		int n;
		@(posedge clk50);
		#1 psel = 1'b1; // setup phase
		pwrite = wr;
		paddr  = a;
		pwdata = d;
		@(posedge clk50);
		#1 penable = 1'b1;
		n = 0;
		@(negedge clk50);
		while (!pready && n < LIMIT) begin
			@(negedge clk50);
			n++;
		end
		if (!pready)
			report_timeout("apb pready");
		rd  = prdata;     // sampled mid access phase
		err = pslverr;
		@(posedge clk50);
		#1 psel = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t a, input apb_data_t d);
		apb_data_t rd;
		logic      err;
		apb_access(1'b1, a, d, rd, err);
		check_data("pslverr", '0, {31'b0, err});
	endtask

	task automatic apply_cfg();
		write_reg(`PID_REG_SETP, {14'b0, m_sp});
		write_reg(`PID_REG_PCOEF, {16'b0, m_p});
		write_reg(`PID_REG_ICOEF, {16'b0, m_i});
		write_reg(`PID_REG_DCOEF, {16'b0, m_d});
		write_reg(`PID_REG_MULT, {22'b0, m_mult});
		write_reg(`PID_REG_SHIFT, {26'b0, m_shift});
		write_reg(`PID_REG_INIT, {16'b0, m_init});
		write_reg(`PID_REG_MIN, {16'b0, m_min});
		write_reg(`PID_REG_MAX, {16'b0, m_max});
		write_reg(`PID_REG_CTRL, apb_data_t'((m_osm << 1) | int'(m_lock)));
		if (!m_lock) begin  // core holds its state at zero while unlocked
			m_integ = 0;
			m_prev  = 0;
		end
	endtask

	////////////////////////////////////////
	// model from filter output to dac code
	////////////////////////////////////////
	function automatic dac_code_t model_step(input longint avg);
		longint err, pid, scaled, biased;
		if (!m_lock) begin
			m_integ = 0;
			m_prev  = 0;
			return m_init;
		end
		err     = longint'(m_sp) - avg;
		m_integ = m_integ + err;
		pid     = longint'(m_p) * err + longint'(m_i) * m_integ
		        + longint'(m_d) * (err - m_prev);
		m_prev  = err;
		scaled  = (pid * longint'(m_mult)) >>> m_shift;
		biased  = scaled + longint'(m_init);
		if (biased > longint'(m_max))
			return m_max;
		else if (biased < longint'(m_min))
			return m_min;
		return dac_code_t'(biased);
	endfunction

	////////////////////////////////////////
	// stimulus and frame capture
	////////////////////////////////////////
	task automatic capture_frame(output dac_frame_t fr);
		int   n;
		int   nbits;
		logic prev;
		fr = '0;
		n  = 0;
		while (dac_nsync && n < LIMIT) begin
			@(negedge clk50);
			n++;
		end
		if (dac_nsync)
			report_timeout("dac_nsync to fall");
		prev  = dac_sclk;
		nbits = 0;
		n     = 0;
		while (!dac_nsync && n < LIMIT) begin
			@(negedge clk50);
			n++;
			if (prev && !dac_sclk && !dac_nsync) begin  // sclk fell so din is stable
				fr.raw = {fr.raw[30:0], dac_din};
				nbits++;
			end
			prev = dac_sclk;
		end
		if (!dac_nsync)
			report_timeout("dac_nsync to rise");
		else if (nbits != 32) begin
			errors++;
			test_errs++;
			$display("frame had %0d bits instead of 32", nbits);
		end
	endtask

	// sends 2^osm samples with random gaps and returns the frame and floor average
	task automatic run_burst(output dac_frame_t fr, output longint avg);
		longint      sum;
		adc_sample_t s;
		int          g;
		int          k;
		sum = 0;
		repeat (2) @(posedge clk50);  // let a new osm settle in the filter
		for (k = 0; k < (1 << m_osm); k++) begin
			s   = adc_sample_t'($random(seed));
			sum = sum + longint'(s);
			g   = $random(seed) & 3;
			@(posedge clk50);
			#1 adc_data = s;
			adc_valid = 1'b1;
			@(posedge clk50);
			#1 adc_valid = 1'b0;
			repeat (g) @(posedge clk50);
		end
		avg = sum >>> m_osm;
		capture_frame(fr);
	endtask

	task automatic run_checked(input int n_bursts, input logic with_osf);
		dac_frame_t fr, hdr;
		longint     avg;
		apb_data_t  rd;
		logic       err;
		hdr = '0;
		hdr.f.control = `PID_DAC_CMD_WRUPD;
		repeat (n_bursts) begin
			run_burst(fr, avg);
			check_frame_hdr("frame", hdr, fr);
			check_code("frame.data", model_step(avg), fr.f.data);
			if (with_osf) begin
				apb_access(1'b0, `PID_REG_OSF, '0, rd, err);
				check_data("pslverr", '0, {31'b0, err});
				check_data("osf", {14'b0, adc_sample_t'(avg)}, rd);
			end
		end
	endtask

	function automatic int rnd_range(input int n);
		return ($random(seed) & 32'h7fffffff) % n;
	endfunction

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	apb_addr_t reg_addr[10] = '{`PID_REG_CTRL, `PID_REG_SETP, `PID_REG_PCOEF,
		`PID_REG_ICOEF, `PID_REG_DCOEF, `PID_REG_MULT, `PID_REG_SHIFT,
		`PID_REG_INIT, `PID_REG_MIN, `PID_REG_MAX};
	apb_data_t reg_mask[10] = '{32'hF, 32'h3FFFF, 32'hFFFF, 32'hFFFF, 32'hFFFF,
		32'h3FF, 32'h3F, 32'hFFFF, 32'hFFFF, 32'hFFFF};

	initial begin
		apb_data_t d, rd;
		logic      err;
		int        k;
		seed         = 32'h53d950f9;
		errors       = 0;
		test_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		clk50     = 1'b0;
		arst_n    = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		adc_data  = '0;
		adc_valid = 1'b0;
		m_integ   = 0;
		m_prev    = 0;
		repeat (5) @(posedge clk50);
		#1 arst_n = 1'b1;

		// register access
		for (k = 0; k < 10; k++) begin
			d = $random(seed);
			write_reg(reg_addr[k], d);
			apb_access(1'b0, reg_addr[k], '0, rd, err);
			check_data("pslverr", '0, {31'b0, err});
			check_data("prdata", d & reg_mask[k], rd);
		end
		apb_access(1'b0, 8'h2C, '0, rd, err);  // unmapped
		check_data("pslverr", 32'h1, {31'b0, err});
		apb_access(1'b1, `PID_REG_OSF, 32'h1234, rd, err);
		check_data("pslverr", 32'h1, {31'b0, err});
		end_test("register access");

		// oversampling while unlocked so frames carry init
		m_lock  = 1'b0;
		m_sp    = '0;
		m_p     = '0;
		m_i     = '0;
		m_d     = '0;
		m_mult  = 10'd1;
		m_shift = '0;
		m_min   = '0;
		m_max   = 16'hFFFF;
		for (k = 0; k < 5; k++) begin
			m_osm  = rnd_range(5);
			m_init = dac_code_t'($random(seed));
			apply_cfg();
			run_checked(1, 1'b1);
		end
		end_test("oversampling");

		// unlocked output
		for (k = 0; k < 6; k++) begin
			m_osm  = rnd_range(3);
			m_init = dac_code_t'($random(seed));
			apply_cfg();
			run_checked(1, 1'b0);
		end
		end_test("unlocked output");

		// closed loop with small gains
		m_lock  = 1'b1;
		m_osm   = rnd_range(3);
		m_sp    = adc_sample_t'($random(seed));
		m_p     = coef_t'(rnd_range(9) - 4);
		m_i     = coef_t'(rnd_range(9) - 4);
		m_d     = coef_t'(rnd_range(9) - 4);
		m_mult  = 10'(rnd_range(16) + 1);
		m_shift = 6'(rnd_range(7) + 4);
		m_init  = 16'h8000;
		m_min   = 16'h1000;
		m_max   = 16'hF000;
		apply_cfg();
		run_checked(40, 1'b0);
		end_test("closed loop");

		// large gain drives the code to a limit
		m_p     = (rnd_range(2) == 0) ? 16'sh4000 : -16'sh4000;
		m_i     = '0;
		m_d     = '0;
		m_mult  = 10'h3FF;
		m_shift = '0;
		m_min   = dac_code_t'(rnd_range(16'h4000));
		m_max   = dac_code_t'(16'hC000 + rnd_range(16'h3FFF));
		apply_cfg();
		run_checked(10, 1'b0);
		end_test("clamping");

		// integrator clear
		m_p     = 16'sd2;
		m_i     = 16'sd1;
		m_d     = -16'sd1;
		m_mult  = 10'd4;
		m_shift = 6'd8;
		m_min   = '0;
		m_max   = 16'hFFFF;
		apply_cfg();
		run_checked(5, 1'b0);
		m_lock = 1'b0;
		apply_cfg();                 // model restarts from zero here
		m_lock = 1'b1;
		apply_cfg();
		run_checked(5, 1'b0);
		end_test("integrator clear");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- test/pid_controller_sva.sv
`timescale 1ns/1ps

module pid_controller_sva (
	input logic clk50,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic dac_nsync,
	input logic dac_sclk
);

	logic [7:0] low_cnt;  // cycles nsync has been low

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			low_cnt <= '0;
		else if (dac_nsync)
			low_cnt <= '0;
		else
			low_cnt <= low_cnt + 1'b1;
	end

	////////////////////////////////////////
	// apb and dac serial protocol
	////////////////////////////////////////
	a_penable_psel: assert property (@(posedge clk50) disable iff (!arst_n)
		penable |-> psel && $past(psel)) else $error("penable without psel");

	a_slverr_access: assert property (@(posedge clk50) disable iff (!arst_n)
		pslverr |-> psel && penable) else $error("pslverr outside access phase");

	// last rise coincides with nsync going high
	a_sclk_in_frame: assert property (@(posedge clk50) disable iff (!arst_n)
		$changed(dac_sclk) |-> !$past(dac_nsync)) else $error("sclk toggled outside frame");

	a_frame_len: assert property (@(posedge clk50) disable iff (!arst_n)
		$rose(dac_nsync) |-> low_cnt == 8'd64) else $error("nsync low time not 64");

endmodule

bind pid_controller pid_controller_sva sva (.clk50, .arst_n, .psel, .penable, .pslverr,
	.dac_nsync, .dac_sclk);

//--- design/pid_controller.sv
`timescale 1ns/1ps

module pid_controller (
	input  logic                 clk50,
	input  logic                 arst_n,
	// apb slave
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  pid_pkg::apb_addr_t   paddr,
	input  pid_pkg::apb_data_t   pwdata,
	output pid_pkg::apb_data_t   prdata,
	output logic                 pready,
	output logic                 pslverr,
	// parallel adc samples
	input  pid_pkg::adc_sample_t adc_data,
	input  logic                 adc_valid,
	// dac8568 serial pins
	output logic                 dac_nsync,
	output logic                 dac_sclk,
	output logic                 dac_din
);
	import pid_pkg::*;

	adc_sample_t osf_data;   // filter -> pid core, readback
	logic        osf_valid;
	comp_t       pid_data;   // pid core -> opp
	logic        pid_valid;
	dac_code_t   dac_code;   // opp -> dac controller
	logic        code_valid;

	pid_cfg_if cfg ();

	////////////////////////////////////////
	// config and signal chain
	////////////////////////////////////////
	pid_regs u_regs (.clk50, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .osf_data, .osf_valid, .cfg(cfg.regs));

	oversample_filter u_osf (.clk50, .arst_n, .adc_data, .adc_valid,
		.cfg(cfg.filt), .osf_data, .osf_valid);

	pid_core u_pid (.clk50, .arst_n, .osf_data, .osf_valid,
		.cfg(cfg.ctrl), .pid_data, .pid_valid);

	output_preprocessor u_opp (.clk50, .arst_n, .pid_data, .pid_valid,
		.cfg(cfg.ctrl), .dac_code, .code_valid);

	dac_controller u_dac (.clk50, .arst_n, .dac_code, .code_valid,
		.dac_nsync, .dac_sclk, .dac_din);

endmodule

//--- design/dac_controller.sv
`timescale 1ns/1ps

`include "pid_config.svh"

module dac_controller (
	input  logic               clk50,
	input  logic               arst_n,
	input  pid_pkg::dac_code_t dac_code,
	input  logic               code_valid,
	output logic               dac_nsync,
	output logic               dac_sclk,
	output logic               dac_din
);
	import pid_pkg::*;

	localparam int N_HALF = 2 * `PID_DAC_FRAME_W;  // sclk half periods per frame
	localparam int W_CNT  = $clog2(N_HALF);
	localparam logic [W_CNT-1:0] CNT_LAST = W_CNT'(N_HALF - 1);

	logic [W_CNT-1:0]            bit_cnt;    // half periods into the frame
	logic [`PID_DAC_FRAME_W-1:0] shreg;
	logic                        pend_valid; // one code waiting behind a frame
	dac_code_t                   pend_code;
	logic                        gap;        // extra nsync high cycle after a frame
	logic                        ready;
	logic                        start;
	dac_code_t                   load_code;
	dac_frame_t                  frame;

	assign ready     = dac_nsync && !gap;
	assign start     = ready && (code_valid || pend_valid);
	assign load_code = code_valid ? dac_code : pend_code;  // newest code wins

	// write and update channel a
	always_comb begin
		frame.f.prefix  = 4'h0;
		frame.f.control = `PID_DAC_CMD_WRUPD;
		frame.f.address = `PID_DAC_ADDR_A;
		frame.f.data    = load_code;
		frame.f.feature = 4'h0;
	end

	////////////////////////////////////////
	// pending code
	////////////////////////////////////////
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			pend_valid <= 1'b0;
		else if (code_valid && !ready)
			pend_valid <= 1'b1;
		else if (start)
			pend_valid <= 1'b0;
	end

	always_ff @(posedge clk50)
		if (code_valid && !ready)
			pend_code <= dac_code;

	////////////////////////////////////////
	// serial frame, din moves on sclk rise
	////////////////////////////////////////
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			dac_nsync <= 1'b1;
			dac_sclk  <= 1'b1;
			dac_din   <= 1'b0;
			bit_cnt   <= '0;
			gap       <= 1'b0;
		end else if (start) begin
			dac_nsync <= 1'b0;
			dac_sclk  <= 1'b1;
			dac_din   <= frame.raw[`PID_DAC_FRAME_W-1];  // msb first
			bit_cnt   <= '0;
		end else if (!dac_nsync) begin
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == CNT_LAST) begin   // last falling edge done
				dac_nsync <= 1'b1;
				dac_sclk  <= 1'b1;
				dac_din   <= 1'b0;
				gap       <= 1'b1;
			end else begin
				dac_sclk <= ~dac_sclk;
				if (!dac_sclk)
					dac_din <= shreg[`PID_DAC_FRAME_W-2];
			end
		end else begin
			gap <= 1'b0;
		end
	end

	always_ff @(posedge clk50)
		if (start)
			shreg <= frame.raw;
		else if (!dac_nsync && !dac_sclk)
			shreg <= shreg << 1;

endmodule

//--- design/output_preprocessor.sv
`timescale 1ns/1ps

module output_preprocessor (
	input  logic               clk50,
	input  logic               arst_n,
	input  pid_pkg::comp_t     pid_data,
	input  logic               pid_valid,
	pid_cfg_if.ctrl            cfg,
	output pid_pkg::dac_code_t dac_code,
	output logic               code_valid
);
	import pid_pkg::*;

	comp_t     mult_ext;
	comp_t     init_ext;
	comp_t     min_ext;
	comp_t     max_ext;
	comp_t     scaled;    // gain applied
	comp_t     biased;    // offset applied
	dac_code_t clamped;

	////////////////////////////////////////
	// scale, offset, clamp
	////////////////////////////////////////
	always_comb begin
		mult_ext = cfg.mult;  // zero extend unsigned config
		init_ext = cfg.init;
		min_ext  = cfg.min;
		max_ext  = cfg.max;
		scaled   = (pid_data * mult_ext) >>> cfg.shift;
		biased   = scaled + init_ext;
		if (biased > max_ext)        // signed 64 bit compare
			clamped = cfg.max;
		else if (biased < min_ext)
			clamped = cfg.min;
		else
			clamped = dac_code_t'(biased);
	end

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			code_valid <= 1'b0;
		else
			code_valid <= pid_valid;
	end

	// unlocked output sits at init
	always_ff @(posedge clk50)
		if (pid_valid)
			dac_code <= cfg.lock_en ? clamped : cfg.init;

endmodule

//--- design/pid_core.sv
`timescale 1ns/1ps

module pid_core (
	input  logic                 clk50,
	input  logic                 arst_n,
	input  pid_pkg::adc_sample_t osf_data,
	input  logic                 osf_valid,
	pid_cfg_if.ctrl              cfg,
	output pid_pkg::comp_t       pid_data,
	output logic                 pid_valid
);
	import pid_pkg::*;

	comp_t integ;      // accumulated error
	comp_t err_prev;   // error of the previous sample
	comp_t sp_ext;
	comp_t smp_ext;
	comp_t err;
	comp_t integ_nxt;
	comp_t p_ext;
	comp_t i_ext;
	comp_t d_ext;
	comp_t sum;

	////////////////////////////////////////
	// p + i + d, all 64 bit wrapping
	////////////////////////////////////////
	always_comb begin
		sp_ext    = cfg.setpoint;  // sign extend operands
		smp_ext   = osf_data;
		p_ext     = cfg.p_coef;
		i_ext     = cfg.i_coef;
		d_ext     = cfg.d_coef;
		err       = sp_ext - smp_ext;
		integ_nxt = integ + err;    // integral includes this sample
		sum       = p_ext * err
		          + i_ext * integ_nxt
		          + d_ext * (err - err_prev);
	end

	// loop state, cleared for as long as the lock is off
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			integ     <= '0;
			err_prev  <= '0;
			pid_valid <= 1'b0;
		end else begin
			pid_valid <= osf_valid;  // valid even when unlocked
			if (!cfg.lock_en) begin
				integ    <= '0;
				err_prev <= '0;
			end else if (osf_valid) begin
				integ    <= integ_nxt;
				err_prev <= err;
			end
		end
	end

	always_ff @(posedge clk50)
		if (osf_valid)
			pid_data <= cfg.lock_en ? sum : '0;

endmodule

//--- design/oversample_filter.sv
`timescale 1ns/1ps

`include "pid_config.svh"

module oversample_filter (
	input  logic                 clk50,
	input  logic                 arst_n,
	input  pid_pkg::adc_sample_t adc_data,
	input  logic                 adc_valid,
	pid_cfg_if.filt              cfg,
	output pid_pkg::adc_sample_t osf_data,
	output logic                 osf_valid
);
	import pid_pkg::*;

	localparam int W_CNT = (1 << `PID_W_OSM) - 1;  // max osm, also log2 of max count
	localparam int W_ACC = `PID_W_ADC + W_CNT;     // room for 2^max_osm samples

	logic signed [W_ACC-1:0] acc;        // running sum of the current block
	logic signed [W_ACC-1:0] sample_ext;
	logic signed [W_ACC-1:0] sum;
	logic [W_CNT-1:0]        cnt;        // samples already in acc
	logic [W_CNT-1:0]        cnt_last;
	logic [`PID_W_OSM-1:0]   osm_q;      // mode the current block runs with
	logic                    done;

	assign sample_ext = adc_data;  // sign extend
	assign sum        = acc + sample_ext;
	assign cnt_last   = W_CNT'((1 << osm_q) - 1);
	assign done       = adc_valid && (cfg.osm == osm_q) && (cnt == cnt_last);

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			acc       <= '0;
			cnt       <= '0;
			osm_q     <= '0;
			osf_valid <= 1'b0;
		end else begin
			osf_valid <= done;
			if (cfg.osm != osm_q) begin  // mode change, drop partial block
				osm_q <= cfg.osm;
				acc   <= '0;
				cnt   <= '0;
			end else if (done) begin
				acc <= '0;
				cnt <= '0;
			end else if (adc_valid) begin
				acc <= sum;
				cnt <= cnt + 1'b1;
			end
		end
	end

	// floor average, arithmetic shift rounds toward -inf
	always_ff @(posedge clk50)
		if (done)
			osf_data <= adc_sample_t'(sum >>> osm_q);

endmodule

//--- design/pid_regs.sv
`timescale 1ns/1ps

`include "pid_config.svh"

module pid_regs (
	input  logic                 clk50,
	input  logic                 arst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  pid_pkg::apb_addr_t   paddr,
	input  pid_pkg::apb_data_t   pwdata,
	output pid_pkg::apb_data_t   prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  pid_pkg::adc_sample_t osf_data,
	input  logic                 osf_valid,
	pid_cfg_if.regs              cfg
);
	import pid_pkg::*;

	logic                    lock_en_r;
	logic [`PID_W_OSM-1:0]   osm_r;
	adc_sample_t             setp_r;
	coef_t                   pcoef_r;
	coef_t                   icoef_r;
	coef_t                   dcoef_r;
	logic [`PID_W_MLT-1:0]   mult_r;
	logic [`PID_W_SHIFT-1:0] shift_r;
	dac_code_t               init_r;
	dac_code_t               min_r;
	dac_code_t               max_r;
	adc_sample_t             osf_r;     // readback of last filter output
	logic                    access;    // apb access phase
	logic                    hit;       // address is mapped
	logic                    wr_en;

	////////////////////////////////////////
	// decode and read mux
	////////////////////////////////////////
	assign access  = psel && penable;
	assign pready  = 1'b1;           // no wait states
	assign pslverr = access && (!hit || (pwrite && paddr == `PID_REG_OSF));
	assign wr_en   = access && pwrite && !pslverr;

	always_comb begin
		prdata = '0; // unused bits read as zero
		hit    = 1'b1;
		case (paddr)
			`PID_REG_CTRL: begin
				prdata[0]            = lock_en_r;
				prdata[`PID_W_OSM:1] = osm_r;
			end
			`PID_REG_SETP:  prdata[`PID_W_ADC-1:0]   = setp_r;
			`PID_REG_PCOEF: prdata[`PID_W_COEF-1:0]  = pcoef_r;
			`PID_REG_ICOEF: prdata[`PID_W_COEF-1:0]  = icoef_r;
			`PID_REG_DCOEF: prdata[`PID_W_COEF-1:0]  = dcoef_r;
			`PID_REG_MULT:  prdata[`PID_W_MLT-1:0]   = mult_r;
			`PID_REG_SHIFT: prdata[`PID_W_SHIFT-1:0] = shift_r;
			`PID_REG_INIT:  prdata[`PID_W_DAC-1:0]   = init_r;
			`PID_REG_MIN:   prdata[`PID_W_DAC-1:0]   = min_r;
			`PID_REG_MAX:   prdata[`PID_W_DAC-1:0]   = max_r;
			`PID_REG_OSF:   prdata[`PID_W_ADC-1:0]   = osf_r;
			default:        hit = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// register writes, commit at access edge
	////////////////////////////////////////
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			lock_en_r <= 1'b0;
			osm_r     <= '0;
			setp_r    <= '0;
			pcoef_r   <= '0;
			icoef_r   <= '0;
			dcoef_r   <= '0;
			mult_r    <= `PID_W_MLT'(1);  // unity gain
			shift_r   <= '0;
			init_r    <= '0;
			min_r     <= '0;
			max_r     <= '1;              // full scale
			osf_r     <= '0;
		end else begin
			if (osf_valid)
				osf_r <= osf_data;
			if (wr_en) begin
				case (paddr)
					`PID_REG_CTRL: begin
						lock_en_r <= pwdata[0];
						osm_r     <= pwdata[`PID_W_OSM:1];
					end
					`PID_REG_SETP:  setp_r  <= pwdata[`PID_W_ADC-1:0];
					`PID_REG_PCOEF: pcoef_r <= pwdata[`PID_W_COEF-1:0];
					`PID_REG_ICOEF: icoef_r <= pwdata[`PID_W_COEF-1:0];
					`PID_REG_DCOEF: dcoef_r <= pwdata[`PID_W_COEF-1:0];
					`PID_REG_MULT:  mult_r  <= pwdata[`PID_W_MLT-1:0];
					`PID_REG_SHIFT: shift_r <= pwdata[`PID_W_SHIFT-1:0];
					`PID_REG_INIT:  init_r  <= pwdata[`PID_W_DAC-1:0];
					`PID_REG_MIN:   min_r   <= pwdata[`PID_W_DAC-1:0];
					`PID_REG_MAX:   max_r   <= pwdata[`PID_W_DAC-1:0];
					default: ;
				endcase
			end
		end
	end

	// live config, seen by the datapath the cycle after a write
	assign cfg.lock_en  = lock_en_r;
	assign cfg.osm      = osm_r;
	assign cfg.setpoint = setp_r;
	assign cfg.p_coef   = pcoef_r;
	assign cfg.i_coef   = icoef_r;
	assign cfg.d_coef   = dcoef_r;
	assign cfg.mult     = mult_r;
	assign cfg.shift    = shift_r;
	assign cfg.init     = init_r;
	assign cfg.min      = min_r;
	assign cfg.max      = max_r;

endmodule

//--- design/pid_cfg_if.sv
`timescale 1ns/1ps

`include "pid_config.svh"

// live configuration from the register block to the datapath
interface pid_cfg_if;
	import pid_pkg::*;

	logic                    lock_en;   // loop closed when high
	logic [`PID_W_OSM-1:0]   osm;       // oversample mode
	adc_sample_t             setpoint;
	coef_t                   p_coef;
	coef_t                   i_coef;
	coef_t                   d_coef;
	logic [`PID_W_MLT-1:0]   mult;      // opp gain
	logic [`PID_W_SHIFT-1:0] shift;     // opp attenuation
	dac_code_t               init;      // output offset, also the unlocked code
	dac_code_t               min;
	dac_code_t               max;

	modport regs (output lock_en, osm, setpoint, p_coef, i_coef, d_coef,
		mult, shift, init, min, max);

	modport filt (input osm);

	// shared by pid core and output preprocessor
	modport ctrl (input lock_en, setpoint, p_coef, i_coef, d_coef,
		mult, shift, init, min, max);

endinterface

//--- design/pid_pkg.sv
`include "pid_config.svh"

package pid_pkg;

	// datapath words
	typedef logic signed [`PID_W_ADC-1:0]  adc_sample_t;
	typedef logic signed [`PID_W_COMP-1:0] comp_t;      // wraps on overflow
	typedef logic signed [`PID_W_COEF-1:0] coef_t;
	typedef logic        [`PID_W_DAC-1:0]  dac_code_t;

	// apb bus words
	typedef logic [`PID_APB_AW-1:0] apb_addr_t;
	typedef logic [`PID_APB_DW-1:0] apb_data_t;

	// dac8568 input shift register layout, msb goes out first
	typedef struct packed {
		logic [3:0] prefix;   // always zero
		logic [3:0] control;  // command nibble
		logic [3:0] address;  // channel a = 0
		dac_code_t  data;
		logic [3:0] feature;  // unused for plain writes
	} dac_fields_t;

	// same 32 bits seen as a raw word for the shifter
	typedef union packed {
		logic [`PID_DAC_FRAME_W-1:0] raw;
		dac_fields_t                 f;
	} dac_frame_t;

endpackage

//--- design/pid_config.svh
`ifndef PID_CONFIG_SVH
`define PID_CONFIG_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
`define PID_W_ADC         18    // adc sample, signed
`define PID_W_COMP        64    // pid / opp computation word
`define PID_W_COEF        16    // p, i, d coefficients, signed
`define PID_W_DAC         16    // dac code, unsigned
`define PID_W_MLT         10    // opp multiplier, unsigned
`define PID_W_SHIFT       6     // opp right shift count
`define PID_W_OSM         3     // oversample mode, 2^osm samples per output

////////////////////////////////////////
// apb register map
////////////////////////////////////////
`define PID_APB_AW        8
`define PID_APB_DW        32
`define PID_REG_CTRL      8'h00 // [0] lock_en, [3:1] osm
`define PID_REG_SETP      8'h04
`define PID_REG_PCOEF     8'h08
`define PID_REG_ICOEF     8'h0C
`define PID_REG_DCOEF     8'h10
`define PID_REG_MULT      8'h14
`define PID_REG_SHIFT     8'h18
`define PID_REG_INIT      8'h1C
`define PID_REG_MIN       8'h20
`define PID_REG_MAX       8'h24
`define PID_REG_OSF       8'h28 // read only, last filtered sample

////////////////////////////////////////
// dac8568 write frame
////////////////////////////////////////
`define PID_DAC_FRAME_W   32
`define PID_DAC_CMD_WRUPD 4'h3  // write input reg n and update dac reg n
`define PID_DAC_ADDR_A    4'h0

`endif
